/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := basilisk_add_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_TEXT := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* list.f */
+incdir+verilog
verilog/basilisk_pkg.sv
verilog/basilisk_add_exponent.sv
verilog/basilisk_add_operation.sv
verilog/basilisk_add_normalize.sv
verilog/basilisk_add_unit.sv
sim/basilisk_add_chk.sv
sim/basilisk_add_tb.sv

/* sim/add_trace.txt */
# each line holds dest_reg operand_a operand_b result overflow inexact in hex
# results follow binary32 round to nearest even with subnormals flushed to zero
01 3f800000 3f800000 40000000 0 0
02 3f800000 40000000 40400000 0 0
03 3fc00000 3e800000 3fe00000 0 0
04 42c80000 3f000000 42c90000 0 0
05 3f800000 30800000 3f800000 0 1
# opposite signs
06 40400000 bf800000 40000000 0 0
07 3f800000 bfc00000 bf000000 0 0
08 3f800001 bf800000 34000000 0 0
09 40490fdb c0490fdb 00000000 0 0
0a c0490fdb 40490fdb 00000000 0 0
0b 3f800000 b3000000 3f800000 0 1
0c 3f800000 b0800000 3f800000 0 1
# rounding ties and near ties
0d 3f800000 33800000 3f800000 0 1
0e 3f800001 33800000 3f800002 0 1
0f 3fffffff 3f800000 40400000 0 1
10 3f800001 3f800000 40000000 0 1
11 3f800000 33c00000 3f800001 0 1
# overflow and subnormals
12 7f7fffff 7f7fffff 7f800000 1 1
13 ff7fffff ff7fffff ff800000 1 1
14 00400000 3f800000 3f800000 0 0
15 00800001 80800000 00000000 0 1
16 80800001 00800000 80000000 0 1
1f 80400000 00400000 00000000 0 0

/* sim/basilisk_add_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module basilisk_add_chk (
    input logic clk,
    input logic arst_n,
    input logic cmd_ready,
    input basilisk_pkg::add_result_t res,
    input logic res_valid,
    input logic res_ready
);

    reset_clears_valid: assert property (@(posedge clk) !arst_n |-> !res_valid)
        else $error("res_valid is high while arst_n is low");

    // a stalled result has to wait unchanged for its consumer
    result_held: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid && !res_ready |=> res_valid && $stable(res))
        else $error("res changed or was dropped while stalled");

    ready_passes_through: assert property (@(posedge clk) disable iff (!arst_n)
        res_ready |-> cmd_ready)
        else $error("cmd_ready is low although res_ready is high");

endmodule

bind basilisk_add_unit basilisk_add_chk chk_inst (
    .clk(clk),
    .arst_n(arst_n),
    .cmd_ready(cmd_ready),
    .res(res),
    .res_valid(res_valid),
    .res_ready(res_ready)
);

`default_nettype wire

/* sim/basilisk_add_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module basilisk_add_tb;

    logic clk;
    logic arst_n;
    basilisk_pkg::add_command_t cmd;
    logic cmd_valid;
    logic cmd_ready;
    basilisk_pkg::add_result_t res;
    logic res_valid;
    logic res_ready = 1'b0;

    basilisk_pkg::add_command_t commands[$];
    basilisk_pkg::add_result_t expected_results[$];
    int pending[$]; // trace index of every accepted command, oldest first
    int accept_cycle[$];
    int cmd_index;
    int cycle_count = 0;
    int timeout_limit = 1000;
    int check_count = 0;
    int error_count = 0;
    int errors_before = 0;
    logic stall_mode = 1'b0;
    logic check_latency = 1'b0;

    basilisk_add_unit dut (
        .clk, .arst_n,
        .cmd, .cmd_valid, .cmd_ready,
        .res, .res_valid, .res_ready
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] wanted,
                               input string what);
        check_count++;
        if (actual !== wanted) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, actual, wanted);
            error_count++;
        end
    endtask

    task automatic read_trace();
        int fd;
        int fields;
        string line;
        logic [31:0] addr;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] word;
        logic [31:0] ovf;
        logic [31:0] inx;
        basilisk_pkg::add_command_t c;
        basilisk_pkg::add_result_t r;
        fd = $fopen("sim/add_trace.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h %h %h %h", addr, op_a, op_b, word, ovf, inx);
                if (fields == 6) begin // comment lines match no field
                    c.dest_reg_addr = addr[4:0];
                    c.operand_a.raw = op_a;
                    c.operand_b.raw = op_b;
                    r.dest_reg_addr = addr[4:0];
                    r.result.raw = word;
                    r.overflow = ovf[0];
                    r.inexact = inx[0];
                    commands.push_back(c);
                    expected_results.push_back(r);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_result();
        int idx;
        int started;
        basilisk_pkg::add_result_t want;
        if (pending.size() == 0) begin
            $display("a result arrived at %0t with no command outstanding", $time);
            error_count++;
        end else begin
            idx = pending.pop_front();
            started = accept_cycle.pop_front();
            want = expected_results[idx];
            check_value(32'(res.dest_reg_addr), 32'(commands[idx].dest_reg_addr),
                        $sformatf("vector %0d address", idx));
            check_value(res.result.raw, want.result.raw, $sformatf("vector %0d result", idx));
            check_value(32'(res.overflow), 32'(want.overflow),
                        $sformatf("vector %0d overflow", idx));
            check_value(32'(res.inexact), 32'(want.inexact),
                        $sformatf("vector %0d inexact", idx));
            if (check_latency) begin
                check_value(cycle_count - started, 3, $sformatf("vector %0d latency", idx));
            end
        end
    endtask

    task automatic run_trace(input logic gaps);
        @(posedge clk);
        for (int i = 0; i < commands.size(); i++) begin
            while (gaps && ($urandom % 4) == 0) begin
                cmd_valid <= 1'b0; // idle cycle between two commands
                @(posedge clk);
            end
            cmd <= commands[i];
            cmd_index <= i;
            cmd_valid <= 1'b1;
            do begin
                @(negedge clk);
            end while (!cmd_ready);
            @(posedge clk); // the transfer happens on this edge
        end
        cmd_valid <= 1'b0;
        while (pending.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d errors", name, error_count - errors_before);
        errors_before = error_count;
    endtask

    task automatic end_run();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // handshakes are sampled half a cycle before the edge that completes them
    always @(negedge clk) begin
        if (arst_n) begin
            if (cmd_valid && cmd_ready) begin
                pending.push_back(cmd_index);
                accept_cycle.push_back(cycle_count);
            end
            if (res_valid && res_ready) begin
                compare_result();
            end
        end
    end

    always @(posedge clk) begin
        res_ready <= stall_mode ? (($urandom % 2) == 0) : 1'b1;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("run timed out after %0d cycles with %0d results still outstanding",
                     cycle_count, pending.size());
            error_count++;
            end_run();
        end
    end

    initial begin
        void'($urandom(78));
        arst_n <= 1'b0;
        cmd <= '0;
        cmd_valid <= 1'b0;
        cmd_index <= 0;
        read_trace();
        timeout_limit = 16 + 4 * commands.size() + 200;
        if (commands.size() == 0) begin
            $display("no vectors could be read from sim/add_trace.txt");
            error_count++;
        end else begin
            repeat (16) @(posedge clk);
            arst_n <= 1'b1;
            @(negedge clk);
            check_value(32'(res_valid), 0, "res_valid after reset");
            check_value(32'(cmd_ready), 1, "cmd_ready after reset");
            finish_test("reset");
            check_latency = 1'b1;
            run_trace(1'b0);
            finish_test("back-to-back trace");
            check_latency = 1'b0;
            stall_mode = 1'b1;
            run_trace(1'b1);
            finish_test("stalled trace");
        end
        end_run();
    end

endmodule

`default_nettype wire

/* verilog/basilisk_add_exponent.sv */
`timescale 1ns/1ps
`default_nettype none

`include "basilisk_macros.svh"

module basilisk_add_exponent (
    input logic clk,
    input logic arst_n,

    input basilisk_pkg::add_command_t cmd,
    input logic cmd_valid,
    output logic cmd_ready,

    output basilisk_pkg::add_exponent_command_t exponent_command,
    output logic exponent_valid,
    input logic exponent_ready
);

    logic [`BASILISK_EXP_W-1:0] exp_a;
    logic [`BASILISK_EXP_W-1:0] exp_b;
    logic [`BASILISK_EXP_W-1:0] exp_large;
    logic [`BASILISK_EXP_W-1:0] exp_small;
    logic [`BASILISK_EXP_W-1:0] exp_diff;
    logic [`BASILISK_SIG_W-1:0] man_a;
    logic [`BASILISK_SIG_W-1:0] man_b;
    logic zero_a;
    logic zero_b;
    logic a_larger;
    basilisk_pkg::add_exponent_command_t next_command;

    always_comb begin
        exp_a = cmd.operand_a.fields.exponent;
        exp_b = cmd.operand_b.fields.exponent;

        // a zero exponent means zero or subnormal, both become zero here
        zero_a = (exp_a == '0);
        zero_b = (exp_b == '0);
        man_a = zero_a ? '0 : {1'b1, cmd.operand_a.fields.mantissa};
        man_b = zero_b ? '0 : {1'b1, cmd.operand_b.fields.mantissa};

        a_larger = {exp_a, man_a} >= {exp_b, man_b}; // magnitude compare, ties keep a first
        exp_large = a_larger ? exp_a : exp_b;
        exp_small = a_larger ? exp_b : exp_a;
        exp_diff = exp_large - exp_small;

        next_command.dest_reg_addr = cmd.dest_reg_addr;
        next_command.result_sign = a_larger ? cmd.operand_a.fields.sign
                                            : cmd.operand_b.fields.sign;
        next_command.effective_subtract = cmd.operand_a.fields.sign ^ cmd.operand_b.fields.sign;
        next_command.large_exp = exp_large;
        next_command.large_man = a_larger ? man_a : man_b;
        next_command.small_man = a_larger ? man_b : man_a;
        next_command.zero_small = a_larger ? zero_b : zero_a;

        if (exp_diff > `BASILISK_SHIFT_MAX) begin
            next_command.shift_dist = `BASILISK_SHIFT_W'(`BASILISK_SHIFT_MAX);
        end else begin
            next_command.shift_dist = exp_diff[`BASILISK_SHIFT_W-1:0];
        end
    end

    assign cmd_ready = !exponent_valid || exponent_ready; // a full stage waits for a drain

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exponent_valid <= 1'b0;
        end else if (cmd_ready) begin
            exponent_valid <= cmd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            exponent_command <= next_command;
        end
    end

endmodule

`default_nettype wire

/* verilog/basilisk_add_normalize.sv */
`timescale 1ns/1ps
`default_nettype none

`include "basilisk_macros.svh"

module basilisk_add_normalize (
    input logic clk,
    input logic arst_n,

    input basilisk_pkg::add_operation_command_t operation_command,
    input logic operation_valid,
    output logic operation_ready,

    output basilisk_pkg::add_result_t res,
    output logic res_valid,
    input logic res_ready
);

    localparam int SIG_W = `BASILISK_SIG_W;
    localparam int NORM_W = `BASILISK_SUM_W - 1;
    localparam int EXP_X = `BASILISK_EXP_W + 2; // room for carry and borrow

    logic carry;
    logic [`BASILISK_SHIFT_W-1:0] lzc;
    logic [NORM_W-1:0] norm;
    logic [SIG_W-1:0] mant;
    logic g;
    logic r;
    logic s;
    logic round_up;
    logic [SIG_W:0] mant_rnd;
    logic [EXP_X-1:0] exp_norm;
    logic [EXP_X-1:0] exp_round;
    logic underflow;
    logic overflow;
    basilisk_pkg::add_result_t next_res;

    always_comb begin
        carry = operation_command.sum[`BASILISK_SUM_W-1];
        lzc = `BASILISK_SHIFT_W'(NORM_W);
        for (int i = 0; i < NORM_W; i++) begin
            if (operation_command.sum[i]) lzc = `BASILISK_SHIFT_W'(NORM_W - 1 - i); // highest one wins
        end

        norm = operation_command.sum[NORM_W-1:0] << lzc;
        if (carry) begin
            mant = operation_command.sum[`BASILISK_SUM_W-1 -: SIG_W];
            {g, r} = operation_command.sum[3:2];
            s = |operation_command.sum[1:0];
        end else begin
            mant = norm[NORM_W-1 -: SIG_W];
            {g, r, s} = norm[2:0];
        end
        exp_norm = EXP_X'(operation_command.large_exp) + EXP_X'(carry) - EXP_X'(carry ? 0 : lzc);

        round_up = g && (r || s || mant[0]); // ties go to the even neighbour
        mant_rnd = {1'b0, mant} + (SIG_W+1)'(round_up);
        exp_round = exp_norm + EXP_X'(mant_rnd[SIG_W]);

        underflow = exp_round[EXP_X-1] || exp_round == '0;
        overflow = !exp_round[EXP_X-1] && exp_round > EXP_X'(2 * `BASILISK_BIAS);

        next_res.dest_reg_addr = operation_command.dest_reg_addr;
        next_res.result.fields.sign = operation_command.result_sign;
        next_res.overflow = 1'b0;
        if (operation_command.sum == '0) begin
            next_res.result.fields.exponent = '0;
            next_res.result.fields.mantissa = '0;
            next_res.inexact = 1'b0;
        end else if (overflow) begin
            next_res.result.fields.exponent = '1; // signed infinity
            next_res.result.fields.mantissa = '0;
            next_res.overflow = 1'b1;
            next_res.inexact = 1'b1;
        end else if (underflow) begin
            next_res.result.fields.exponent = '0; // tiny results flush to signed zero
            next_res.result.fields.mantissa = '0;
            next_res.inexact = 1'b1;
        end else begin
            next_res.result.fields.exponent = exp_round[`BASILISK_EXP_W-1:0];
            next_res.result.fields.mantissa = mant_rnd[SIG_W] ? mant_rnd[SIG_W-1:1]
                                                              : mant_rnd[`BASILISK_MAN_W-1:0];
            next_res.inexact = g || r || s;
        end
    end

    assign operation_ready = !res_valid || res_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else if (operation_ready) begin
            res_valid <= operation_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (operation_valid && operation_ready) begin
            res <= next_res;
        end
    end

endmodule

`default_nettype wire

/* verilog/basilisk_add_operation.sv */
`timescale 1ns/1ps
`default_nettype none

`include "basilisk_macros.svh"

module basilisk_add_operation (
    input logic clk,
    input logic arst_n,

    input basilisk_pkg::add_exponent_command_t exponent_command,
    input logic exponent_valid,
    output logic exponent_ready,

    output basilisk_pkg::add_operation_command_t operation_command,
    output logic operation_valid,
    input logic operation_ready
);

    localparam int SIG_W = `BASILISK_SIG_W;
    localparam int WIDE_W = SIG_W + `BASILISK_SHIFT_MAX;

    logic [WIDE_W-1:0] wide;
    logic [SIG_W+2:0] aligned; // significand, guard, round, sticky
    logic [`BASILISK_SUM_W-1:0] large_ext;
    logic [`BASILISK_SUM_W-1:0] small_ext;
    logic [`BASILISK_SUM_W-1:0] sum;
    basilisk_pkg::add_operation_command_t next_command;

    always_comb begin
        wide = {exponent_command.small_man, {`BASILISK_SHIFT_MAX{1'b0}}}
               >> exponent_command.shift_dist;

        if (exponent_command.zero_small) begin
            aligned = '0;
        end else begin
            aligned = {wide[WIDE_W-1 -: SIG_W+2], |wide[WIDE_W-SIG_W-3:0]};
        end

        large_ext = {1'b0, exponent_command.large_man, 3'b000};
        small_ext = {1'b0, aligned};

        // the larger magnitude is first, so the difference never goes negative
        if (exponent_command.effective_subtract) begin
            sum = large_ext - small_ext;
        end else begin
            sum = large_ext + small_ext;
        end

        next_command.dest_reg_addr = exponent_command.dest_reg_addr;
        next_command.large_exp = exponent_command.large_exp;
        next_command.sum = sum;
        // exact cancellation gives +0 under round to nearest
        next_command.result_sign = exponent_command.result_sign
            && !(exponent_command.effective_subtract && sum == '0);
    end

    assign exponent_ready = !operation_valid || operation_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operation_valid <= 1'b0;
        end else if (exponent_ready) begin
            operation_valid <= exponent_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exponent_valid && exponent_ready) begin
            operation_command <= next_command;
        end
    end

endmodule

`default_nettype wire

/* verilog/basilisk_add_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module basilisk_add_unit (
    input logic clk,
    input logic arst_n,

    input basilisk_pkg::add_command_t cmd,
    input logic cmd_valid,
    output logic cmd_ready,

    output basilisk_pkg::add_result_t res,
    output logic res_valid,
    input logic res_ready
);

    basilisk_pkg::add_exponent_command_t exponent_command;
    logic exponent_valid;
    logic exponent_ready;

    basilisk_pkg::add_operation_command_t operation_command;
    logic operation_valid;
    logic operation_ready;

    basilisk_add_exponent exponent_inst (
        .clk, .arst_n,
        .cmd, .cmd_valid, .cmd_ready,
        .exponent_command, .exponent_valid, .exponent_ready
    );

    basilisk_add_operation operation_inst (
        .clk, .arst_n,
        .exponent_command, .exponent_valid, .exponent_ready,
        .operation_command, .operation_valid, .operation_ready
    );

    basilisk_add_normalize normalize_inst (
        .clk, .arst_n,
        .operation_command, .operation_valid, .operation_ready,
        .res, .res_valid, .res_ready
    );

endmodule

`default_nettype wire

/* verilog/basilisk_macros.svh */
`ifndef BASILISK_MACROS_SVH
`define BASILISK_MACROS_SVH

// binary32 field widths
`define BASILISK_EXP_W 8
`define BASILISK_MAN_W 23
`define BASILISK_WORD_W (1 + `BASILISK_EXP_W + `BASILISK_MAN_W)

// biased exponent of 1.0, the largest finite exponent is twice this
`define BASILISK_BIAS 127

// destination register address of the FPU register file
`define BASILISK_REG_W 5

// significand with the hidden bit restored
`define BASILISK_SIG_W (`BASILISK_MAN_W + 1)

// carry, significand, guard, round and sticky
`define BASILISK_SUM_W (`BASILISK_SIG_W + 4)

// alignment distance, anything at or past 27 lands fully in sticky
`define BASILISK_SHIFT_W 5
`define BASILISK_SHIFT_MAX 27

`endif

/* verilog/basilisk_pkg.sv */
`default_nettype none

`include "basilisk_macros.svh"

package basilisk_pkg;

    typedef struct packed {
        logic sign;
        logic [`BASILISK_EXP_W-1:0] exponent;
        logic [`BASILISK_MAN_W-1:0] mantissa;
    } fp_fields_t;

    // the bus sees a raw word, the datapath picks it apart
    typedef union packed {
        logic [`BASILISK_WORD_W-1:0] raw;
        fp_fields_t fields;
    } fp_word_u;

    typedef struct packed {
        logic [`BASILISK_REG_W-1:0] dest_reg_addr;
        fp_word_u operand_a;
        fp_word_u operand_b;
    } add_command_t;

    typedef struct packed {
        logic [`BASILISK_REG_W-1:0] dest_reg_addr;
        logic result_sign;
        logic effective_subtract;
        logic [`BASILISK_EXP_W-1:0] large_exp;
        logic [`BASILISK_SIG_W-1:0] large_man;
        logic [`BASILISK_SIG_W-1:0] small_man;
        logic [`BASILISK_SHIFT_W-1:0] shift_dist;
        logic zero_small;
    } add_exponent_command_t;

    typedef struct packed {
        logic [`BASILISK_REG_W-1:0] dest_reg_addr;
        logic result_sign;
        logic [`BASILISK_EXP_W-1:0] large_exp;
        logic [`BASILISK_SUM_W-1:0] sum; // carry, significand, g, r, s
    } add_operation_command_t;

    typedef struct packed {
        logic [`BASILISK_REG_W-1:0] dest_reg_addr;
        fp_word_u result;
        logic overflow;
        logic inexact;
    } add_result_t;

endpackage

`default_nettype wire
